// File: rtl/cpu_defines.svh
/*
   Machine widths, memory depths, opcodes and control select codes
*/
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Word and register index widths
`define DATA_WIDTH      16
`define REG_ADDR_WIDTH  3

// Word-address widths of the two memories
`define IMEM_ADDR_WIDTH 8
`define DMEM_ADDR_WIDTH 8

// Opcodes, instruction bits 15:11
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_SLBI   5'b10010
`define OP_LBI    5'b11000
`define OP_RTYPE  5'b11011

// ALU operation select
`define ALU_ADD   3'd0
`define ALU_XOR   3'd1
`define ALU_AND   3'd2
`define ALU_PASSB 3'd3
`define ALU_SLBI  3'd4

// B operand source
`define BSRC_REG   2'd0
`define BSRC_SEXT5 2'd1
`define BSRC_ZEXT5 2'd2
`define BSRC_SEXT8 2'd3

// Destination register select
`define DST_RD_R 2'd0
`define DST_RD_I 2'd1
`define DST_RS   2'd2

`endif

// File: rtl/cpuPkg.sv
/*
   Shared types: the instruction word and its four field layouts
*/
`include "cpu_defines.svh"

package cpuPkg;

   // One 16-bit word, read through whichever layout the opcode calls for
   typedef union packed {
      // Register to register ALU ops
      struct packed {
         logic [4:0]                 opcode;
         logic [`REG_ADDR_WIDTH-1:0] rs;
         logic [`REG_ADDR_WIDTH-1:0] rt;
         logic [`REG_ADDR_WIDTH-1:0] rd;
         logic [1:0]                 func;
      } rFmt;
      // 5-bit immediate ops, loads and stores
      struct packed {
         logic [4:0]                 opcode;
         logic [`REG_ADDR_WIDTH-1:0] rs;
         logic [`REG_ADDR_WIDTH-1:0] rd;
         logic [4:0]                 imm;
      } i1Fmt;
      // 8-bit immediate: LBI, SLBI, branches
      struct packed {
         logic [4:0]                 opcode;
         logic [`REG_ADDR_WIDTH-1:0] rs;
         logic [7:0]                 imm;
      } i2Fmt;
      // Jump with 11-bit byte displacement
      struct packed {
         logic [4:0]  opcode;
         logic [10:0] disp;
      } jFmt;
   } instrWord;

endpackage

// File: rtl/ctrlIf.sv
/*
   Decoded control levels from the decoder to the datapath blocks
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

interface ctrlIf;

   // Register file and writeback
   logic       regWrt;
   logic [1:0] regDst;
   // 0 picks the ALU result, 1 the load data
   logic       regSrc;

   // ALU
   logic [1:0] bSrc;
   logic [2:0] aluOpr;
   logic       invA;
   logic       invB;
   logic       cin;

   // Data memory
   logic       memWrt;
   logic       memRd;

   // Program counter, brType high means branch on nonzero
   logic       isBranch;
   logic       brType;
   logic       isJump;

   // Sequencer
   logic       halt;

   modport decoder (output regWrt, regDst, regSrc, bSrc, aluOpr, invA, invB, cin,
                    memWrt, memRd, isBranch, brType, isJump, halt);
   modport datapath (input regWrt, regDst, regSrc, bSrc, aluOpr, invA, invB, cin,
                     memWrt, memRd, isBranch, brType, isJump, halt);

endinterface

// File: rtl/decode.sv
/*
   Instruction decoder
   Opcode and R-type function bits to datapath control levels
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode import cpuPkg::*; (
   input instrWord   instr,
   ctrlIf.decoder    ctrl
);

   always_comb begin
      //////////////////////////////
      // Defaults behave as NOP
      //////////////////////////////
      ctrl.regWrt   = 1'b0;
      ctrl.regDst   = `DST_RD_I;
      ctrl.regSrc   = 1'b0;
      ctrl.bSrc     = `BSRC_SEXT5;
      ctrl.aluOpr   = `ALU_ADD;
      ctrl.invA     = 1'b0;
      ctrl.invB     = 1'b0;
      ctrl.cin      = 1'b0;
      ctrl.memWrt   = 1'b0;
      ctrl.memRd    = 1'b0;
      ctrl.isBranch = 1'b0;
      ctrl.brType   = 1'b0;
      ctrl.isJump   = 1'b0;
      ctrl.halt     = 1'b0;

      case (instr.rFmt.opcode)
         `OP_HALT: ctrl.halt = 1'b1;
         `OP_J: ctrl.isJump = 1'b1;

         //////////////////////////////
         // 5-bit immediate ALU ops
         //////////////////////////////
         `OP_ADDI: ctrl.regWrt = 1'b1;
         `OP_SUBI: begin
            // imm - rs as imm + ~rs + 1
            ctrl.regWrt = 1'b1;
            ctrl.invA   = 1'b1;
            ctrl.cin    = 1'b1;
         end
         `OP_XORI: begin
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = `BSRC_ZEXT5;
            ctrl.aluOpr = `ALU_XOR;
         end
         `OP_ANDNI: begin
            // rs & ~imm, zero extended before the inversion
            ctrl.regWrt = 1'b1;
            ctrl.bSrc   = `BSRC_ZEXT5;
            ctrl.aluOpr = `ALU_AND;
            ctrl.invB   = 1'b1;
         end

         // Branches test rs, offset comes from the 8-bit field
         `OP_BEQZ: ctrl.isBranch = 1'b1;
         `OP_BNEZ: begin
            ctrl.isBranch = 1'b1;
            ctrl.brType   = 1'b1;
         end

         //////////////////////////////
         // Memory and byte loads
         //////////////////////////////
         // Address rs + sext(imm5) for both
         `OP_ST: ctrl.memWrt = 1'b1;
         `OP_LD: begin
            ctrl.regWrt = 1'b1;
            ctrl.memRd  = 1'b1;
            ctrl.regSrc = 1'b1;
         end
         `OP_SLBI: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = `DST_RS;
            ctrl.bSrc   = `BSRC_SEXT8;
            ctrl.aluOpr = `ALU_SLBI;
         end
         `OP_LBI: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = `DST_RS;
            ctrl.bSrc   = `BSRC_SEXT8;
            ctrl.aluOpr = `ALU_PASSB;
         end

         //////////////////////////////
         // R-type, func picks the op
         //////////////////////////////
         `OP_RTYPE: begin
            ctrl.regWrt = 1'b1;
            ctrl.regDst = `DST_RD_R;
            ctrl.bSrc   = `BSRC_REG;
            case (instr.rFmt.func)
               // ADD
               2'b00: ctrl.aluOpr = `ALU_ADD;
               // SUB, rt - rs
               2'b01: begin
                  ctrl.invA = 1'b1;
                  ctrl.cin  = 1'b1;
               end
               // XOR
               2'b10: ctrl.aluOpr = `ALU_XOR;
               // ANDN, rs & ~rt
               default: begin
                  ctrl.aluOpr = `ALU_AND;
                  ctrl.invB   = 1'b1;
               end
            endcase
         end

         // NOP and undefined opcodes keep the defaults
         default: ;
      endcase
   end

endmodule

// File: rtl/seqControl.sv
/*
   Instruction sequencer
   Fetch, decode, execute, memory, writeback and a halt state
*/
`timescale 1ns/1ps

module seqControl (
   input  logic     clk,
   input  logic     reset,
   ctrlIf.datapath  ctrl,
   output logic     irLoad,
   output logic     exLatch,
   output logic     memStep,
   output logic     wbStep,
   output logic     halted
);

   // State encoding
   localparam logic [2:0] stFetch  = 3'd0;
   localparam logic [2:0] stDecode = 3'd1;
   localparam logic [2:0] stExec   = 3'd2;
   localparam logic [2:0] stMem    = 3'd3;
   localparam logic [2:0] stWb     = 3'd4;
   localparam logic [2:0] stHalted = 3'd5;

   logic [2:0] state;
   logic [2:0] nextState;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stFetch;
      end else begin
         state <= nextState;
      end
   end

   // Fixed five-step walk, HALT leaves it from decode
   always_comb begin
      case (state)
         stFetch:  nextState = stDecode;
         stDecode: nextState = ctrl.halt ? stHalted : stExec;
         stExec:   nextState = stMem;
         stMem:    nextState = stWb;
         stWb:     nextState = stFetch;
         // Only reset gets out of here
         stHalted: nextState = stHalted;
         default:  nextState = stFetch;
      endcase
   end

   //////////////////////////////
   // One strobe per step
   //////////////////////////////
   assign irLoad  = (state == stFetch);
   assign exLatch = (state == stExec);
   assign memStep = (state == stMem);
   assign wbStep  = (state == stWb);
   assign halted  = (state == stHalted);

endmodule

// File: rtl/progCounter.sv
/*
   Program counter with sequential, branch and jump updates
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module progCounter import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   wbStep,
   input  instrWord               instr,
   input  logic                   aZero,
   ctrlIf.datapath                ctrl,
   output logic [`DATA_WIDTH-1:0] pc
);

   logic [`DATA_WIDTH-1:0] pcInc;
   logic [`DATA_WIDTH-1:0] brOff;
   logic [`DATA_WIDTH-1:0] jOff;
   logic [`DATA_WIDTH-1:0] pcNext;
   logic                   brTaken;

   // Byte offsets relative to the next instruction
   assign pcInc = pc + `DATA_WIDTH'(2);
   assign brOff = {{(`DATA_WIDTH-8){instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};
   assign jOff  = {{(`DATA_WIDTH-11){instr.jFmt.disp[10]}}, instr.jFmt.disp};

   // brType low branches on rs == 0
   assign brTaken = ctrl.isBranch & (ctrl.brType ? ~aZero : aZero);

   always_comb begin
      if (ctrl.isJump) begin
         pcNext = pcInc + jOff;
      end else if (brTaken) begin
         pcNext = pcInc + brOff;
      end else begin
         pcNext = pcInc;
      end
   end

   // PC moves once per instruction, in writeback
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
      end else if (wbStep) begin
         pc <= pcNext;
      end
   end

endmodule

// File: rtl/regFile.sv
/*
   Eight-entry register file
   Two combinational reads, one clocked write
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile import cpuPkg::*; (
   input  logic                       clk,
   input  logic                       reset,
   input  instrWord                   instr,
   ctrlIf.datapath                    ctrl,
   input  logic                       wrEn,
   input  logic [`DATA_WIDTH-1:0]     wrData,
   output logic [`DATA_WIDTH-1:0]     rsData,
   output logic [`DATA_WIDTH-1:0]     rtData,
   output logic [`REG_ADDR_WIDTH-1:0] wrReg
);

   logic [`DATA_WIDTH-1:0]     regs [0:(1 << `REG_ADDR_WIDTH)-1];

   // R-type rt and the I1 rd field (store data) share bits 7:5
   assign rsData = regs[instr.rFmt.rs];
   assign rtData = regs[instr.rFmt.rt];

   // Write index
   always_comb begin
      case (ctrl.regDst)
         `DST_RD_R: wrReg = instr.rFmt.rd;
         `DST_RD_I: wrReg = instr.i1Fmt.rd;
         default:   wrReg = instr.rFmt.rs;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrReg] <= wrData;
      end
   end

endmodule

// File: rtl/alu.sv
/*
   ALU: B operand select, inversion and carry-in, result ops, zero test
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu import cpuPkg::*; (
   input  instrWord               instr,
   ctrlIf.datapath                ctrl,
   input  logic [`DATA_WIDTH-1:0] rsData,
   input  logic [`DATA_WIDTH-1:0] rtData,
   output logic [`DATA_WIDTH-1:0] result,
   output logic                   aZero
);

   logic [`DATA_WIDTH-1:0] opB;
   logic [`DATA_WIDTH-1:0] inA;
   logic [`DATA_WIDTH-1:0] inB;

   //////////////////////////////
   // Operand B
   //////////////////////////////
   always_comb begin
      case (ctrl.bSrc)
         `BSRC_REG:   opB = rtData;
         `BSRC_SEXT5: opB = {{(`DATA_WIDTH-5){instr.i1Fmt.imm[4]}}, instr.i1Fmt.imm};
         `BSRC_ZEXT5: opB = {{(`DATA_WIDTH-5){1'b0}}, instr.i1Fmt.imm};
         default:     opB = {{(`DATA_WIDTH-8){instr.i2Fmt.imm[7]}}, instr.i2Fmt.imm};
      endcase
   end

   // Subtract is B + ~A + 1, and-not inverts B
   assign inA = ctrl.invA ? ~rsData : rsData;
   assign inB = ctrl.invB ? ~opB : opB;

   //////////////////////////////
   // Result
   //////////////////////////////
   always_comb begin
      case (ctrl.aluOpr)
         `ALU_ADD:   result = inA + inB + {{(`DATA_WIDTH-1){1'b0}}, ctrl.cin};
         `ALU_XOR:   result = inA ^ inB;
         `ALU_AND:   result = inA & inB;
         `ALU_PASSB: result = inB;
         // Old low byte moves up, new byte fills in zero extended
         `ALU_SLBI:  result = {rsData[`DATA_WIDTH-9:0], instr.i2Fmt.imm};
         default:    result = inA + inB;
      endcase
   end

   // Branch condition looks at rs itself
   assign aZero = (rsData == '0);

endmodule

// File: rtl/instrMem.sv
/*
   Instruction memory, load write port and synchronous fetch read
*/
`timescale 1ns/1ps

module instrMem #(
   parameter int addrWidth = 8,
   parameter int dataWidth = 16
) (
   input  logic                 clk,
   input  logic                 loadEn,
   input  logic [addrWidth-1:0] loadAddr,
   input  logic [dataWidth-1:0] loadData,
   input  logic [addrWidth-1:0] fetchAddr,
   output logic [dataWidth-1:0] fetchData
);

   logic [dataWidth-1:0] mem [0:(1 << addrWidth)-1];

   // Load port only runs under reset, fetch reads every cycle
   always_ff @(posedge clk) begin
      if (loadEn) begin
         mem[loadAddr] <= loadData;
      end
      fetchData <= mem[fetchAddr];
   end

endmodule

// File: rtl/dataMem.sv
/*
   Data memory, synchronous store and load on the memory step
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module dataMem (
   input  logic                   clk,
   input  logic                   memStep,
   input  logic [`DATA_WIDTH-1:0] addr,
   input  logic [`DATA_WIDTH-1:0] wrData,
   ctrlIf.datapath                ctrl,
   output logic [`DATA_WIDTH-1:0] rdData
);

   logic [`DATA_WIDTH-1:0]      mem [0:(1 << `DMEM_ADDR_WIDTH)-1];
   logic [`DMEM_ADDR_WIDTH-1:0] wordAddr;

   // Byte address to word index
   assign wordAddr = addr[`DMEM_ADDR_WIDTH:1];

   always_ff @(posedge clk) begin
      if (memStep) begin
         if (ctrl.memWrt) begin
            mem[wordAddr] <= wrData;
         end
         // Load word is ready in writeback
         if (ctrl.memRd) begin
            rdData <= mem[wordAddr];
         end
      end
   end

endmodule

// File: rtl/cpuTop.sv
/*
   Processor top: sequencer, PC, memories, decoder, register file, ALU
   Also the instruction register, the ALU result register and writeback mux
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTop import cpuPkg::*; (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       loadEn,
   input  logic [`IMEM_ADDR_WIDTH-1:0] loadAddr,
   input  logic [`DATA_WIDTH-1:0]     loadData,
   output logic                       halted,
   output logic                       wbValid,
   output logic [`REG_ADDR_WIDTH-1:0] wbReg,
   output logic [`DATA_WIDTH-1:0]     wbData
);

   ctrlIf ctrl ();

   logic                       irLoad;
   logic                       exLatch;
   logic                       memStep;
   logic                       wbStep;
   logic                       fetchDone;
   logic                       aZero;
   logic [`DATA_WIDTH-1:0]     pc;
   logic [`DATA_WIDTH-1:0]     fetchData;
   logic [`DATA_WIDTH-1:0]     rsData;
   logic [`DATA_WIDTH-1:0]     rtData;
   logic [`DATA_WIDTH-1:0]     aluResult;
   logic [`DATA_WIDTH-1:0]     aluOut;
   logic [`DATA_WIDTH-1:0]     memRdData;
   logic [`REG_ADDR_WIDTH-1:0] wrReg;
   instrWord                   ir;
   instrWord                   instr;

   seqControl uSeq (.clk, .reset, .ctrl(ctrl.datapath), .irLoad, .exLatch, .memStep,
                    .wbStep, .halted);

   progCounter uPc (.clk, .reset, .wbStep, .instr, .aZero, .ctrl(ctrl.datapath), .pc);

   instrMem #(.addrWidth(`IMEM_ADDR_WIDTH), .dataWidth(`DATA_WIDTH)) uImem (
      .clk, .loadEn, .loadAddr, .loadData,
      .fetchAddr(pc[`IMEM_ADDR_WIDTH:1]), .fetchData);

   //////////////////////////////
   // Instruction register
   //////////////////////////////
   // Fetched word shows up the cycle after fetch; decode sees it direct
   // and the IR keeps it for execute, memory and writeback
   always_ff @(posedge clk) begin
      if (reset) begin
         fetchDone <= 1'b0;
      end else begin
         fetchDone <= irLoad;
      end
   end

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         ir <= fetchData;
      end
   end

   assign instr = fetchDone ? fetchData : ir;

   decode uDec (.instr, .ctrl(ctrl.decoder));

   regFile uRf (.clk, .reset, .instr, .ctrl(ctrl.datapath), .wrEn(wbValid),
                .wrData(wbData), .rsData, .rtData, .wrReg);

   alu uAlu (.instr, .ctrl(ctrl.datapath), .rsData, .rtData, .result(aluResult), .aZero);

   // Result held from execute, serves as the memory address too
   always_ff @(posedge clk) begin
      if (exLatch) begin
         aluOut <= aluResult;
      end
   end

   dataMem uDmem (.clk, .memStep, .addr(aluOut), .wrData(rtData), .ctrl(ctrl.datapath),
                  .rdData(memRdData));

   //////////////////////////////
   // Writeback and trace
   //////////////////////////////
   assign wbData  = ctrl.regSrc ? memRdData : aluOut;
   assign wbValid = wbStep & ctrl.regWrt;
   assign wbReg   = wrReg;

endmodule

// File: dv/cpuTb.sv
/*
   Processor testbench: program table, load and run loop, trace checks,
   a random R-type case and a watchdog
*/
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb;

   localparam int numTests    = 7;
   localparam int progLen     = 8;
   localparam int maxWrites   = 6;
   localparam int quietCycles = 20;
   // Tests x (load + reset + 9 instructions of 5 cycles) x 10 ns, doubled
   localparam int watchdogNs  = numTests * (progLen + 2 + 9 * 5) * 10 * 2;

   logic        clk;
   logic        reset;
   logic        loadEn;
   logic [7:0]  loadAddr;
   logic [15:0] loadData;
   logic        halted;
   logic        wbValid;
   logic [2:0]  wbReg;
   logic [15:0] wbData;

   // Test table
   string       names [numTests];
   logic [15:0] progTab [numTests][progLen];
   int          expCount [numTests];
   logic [2:0]  expReg [numTests][maxWrites];
   logic [15:0] expVal [numTests][maxWrites];
   // Executed-instruction number of each write, writeback is cycle 5n+4
   int          expStep [numTests][maxWrites];

   // Observed trace
   logic [2:0]  gotReg [$];
   logic [15:0] gotVal [$];
   int          gotCycle [$];

   int passCount;
   int failCount;
   int seed = 32'h6147608f;

   cpuTop dut (.clk, .reset, .loadEn, .loadAddr, .loadData, .halted, .wbValid, .wbReg,
               .wbData);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////
   // Instruction assembly
   //////////////////////////////
   function automatic logic [15:0] rWord(input logic [1:0] func, input logic [2:0] rs,
                                         input logic [2:0] rt, input logic [2:0] rd);
      return {`OP_RTYPE, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] shortImmWord(input logic [4:0] op, input logic [2:0] rs,
                                                input logic [2:0] rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] byteImmWord(input logic [4:0] op, input logic [2:0] rs,
                                               input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jumpWord(input logic [10:0] disp);
      return {`OP_J, disp};
   endfunction

   task automatic expectWrite(input int t, input logic [2:0] r, input logic [15:0] v,
                              input int step);
      expReg[t][expCount[t]]  = r;
      expVal[t][expCount[t]]  = v;
      expStep[t][expCount[t]] = step;
      expCount[t]++;
   endtask

   //////////////////////////////
   // Directed programs
   //////////////////////////////
   task automatic fillTable();
      for (int t = 0; t < numTests; t++) begin
         expCount[t] = 0;
         // Unused slots stay HALT
         for (int i = 0; i < progLen; i++) begin
            progTab[t][i] = 16'h0000;
         end
      end
      // Constant build, LBI sign extends
      names[0] = "lbi_slbi";
      progTab[0][0] = byteImmWord(`OP_LBI, 3'd1, 8'h12);
      progTab[0][1] = byteImmWord(`OP_SLBI, 3'd1, 8'h34);
      progTab[0][2] = byteImmWord(`OP_LBI, 3'd2, 8'h80);
      progTab[0][3] = byteImmWord(`OP_SLBI, 3'd2, 8'hFF);
      expectWrite(0, 3'd1, 16'h0012, 0);
      expectWrite(0, 3'd1, 16'h1234, 1);
      expectWrite(0, 3'd2, 16'hFF80, 2);
      expectWrite(0, 3'd2, 16'h80FF, 3);
      // Immediates, r1 = 0xFF85
      names[1] = "imm_alu";
      progTab[1][0] = byteImmWord(`OP_LBI, 3'd1, 8'h85);
      progTab[1][1] = shortImmWord(`OP_ADDI, 3'd1, 3'd2, 5'h1F);
      progTab[1][2] = shortImmWord(`OP_SUBI, 3'd1, 3'd3, 5'h03);
      progTab[1][3] = shortImmWord(`OP_XORI, 3'd1, 3'd4, 5'h10);
      progTab[1][4] = shortImmWord(`OP_ANDNI, 3'd1, 3'd5, 5'h14);
      expectWrite(1, 3'd1, 16'hFF85, 0);
      expectWrite(1, 3'd2, 16'hFF84, 1);
      expectWrite(1, 3'd3, 16'h007E, 2);
      expectWrite(1, 3'd4, 16'hFF95, 3);
      expectWrite(1, 3'd5, 16'hFF81, 4);
      // R-type with rs = 12, rt = 10
      names[2] = "rtype";
      progTab[2][0] = byteImmWord(`OP_LBI, 3'd1, 8'h0C);
      progTab[2][1] = byteImmWord(`OP_LBI, 3'd2, 8'h0A);
      progTab[2][2] = rWord(2'b00, 3'd1, 3'd2, 3'd3);
      progTab[2][3] = rWord(2'b01, 3'd1, 3'd2, 3'd4);
      progTab[2][4] = rWord(2'b10, 3'd1, 3'd2, 3'd5);
      progTab[2][5] = rWord(2'b11, 3'd1, 3'd2, 3'd6);
      expectWrite(2, 3'd1, 16'h000C, 0);
      expectWrite(2, 3'd2, 16'h000A, 1);
      expectWrite(2, 3'd3, 16'h0016, 2);
      expectWrite(2, 3'd4, 16'hFFFE, 3);
      expectWrite(2, 3'd5, 16'h0006, 4);
      expectWrite(2, 3'd6, 16'h0004, 5);
      // Store and load at base + 2 and base - 4
      names[3] = "store_load";
      progTab[3][0] = byteImmWord(`OP_LBI, 3'd1, 8'h10);
      progTab[3][1] = byteImmWord(`OP_LBI, 3'd2, 8'hA5);
      progTab[3][2] = shortImmWord(`OP_ST, 3'd1, 3'd2, 5'h02);
      progTab[3][3] = shortImmWord(`OP_LD, 3'd1, 3'd3, 5'h02);
      progTab[3][4] = byteImmWord(`OP_LBI, 3'd5, 8'h33);
      progTab[3][5] = shortImmWord(`OP_ST, 3'd1, 3'd5, 5'h1C);
      progTab[3][6] = shortImmWord(`OP_LD, 3'd1, 3'd6, 5'h1C);
      expectWrite(3, 3'd1, 16'h0010, 0);
      expectWrite(3, 3'd2, 16'hFFA5, 1);
      expectWrite(3, 3'd3, 16'hFFA5, 3);
      expectWrite(3, 3'd5, 16'h0033, 4);
      expectWrite(3, 3'd6, 16'h0033, 6);
      // BEQZ taken, BNEZ not taken, BNEZ taken
      names[4] = "branch";
      progTab[4][0] = byteImmWord(`OP_LBI, 3'd1, 8'h00);
      progTab[4][1] = byteImmWord(`OP_BEQZ, 3'd1, 8'd2);
      progTab[4][2] = byteImmWord(`OP_LBI, 3'd2, 8'h11);
      progTab[4][3] = byteImmWord(`OP_BNEZ, 3'd1, 8'd2);
      progTab[4][4] = byteImmWord(`OP_LBI, 3'd3, 8'h22);
      progTab[4][5] = byteImmWord(`OP_BNEZ, 3'd3, 8'd2);
      progTab[4][6] = byteImmWord(`OP_LBI, 3'd4, 8'h44);
      expectWrite(4, 3'd1, 16'h0000, 0);
      expectWrite(4, 3'd3, 16'h0022, 3);
      // J over two words, then BEQZ not taken
      names[5] = "jump";
      progTab[5][0] = byteImmWord(`OP_LBI, 3'd1, 8'h01);
      progTab[5][1] = jumpWord(11'd4);
      progTab[5][2] = byteImmWord(`OP_LBI, 3'd2, 8'h22);
      progTab[5][3] = byteImmWord(`OP_LBI, 3'd3, 8'h33);
      progTab[5][4] = byteImmWord(`OP_BEQZ, 3'd1, 8'd2);
      progTab[5][5] = byteImmWord(`OP_LBI, 3'd4, 8'h44);
      expectWrite(5, 3'd1, 16'h0001, 0);
      expectWrite(5, 3'd4, 16'h0044, 3);
   endtask

   // Two random bytes and a random function into r7
   task automatic buildRandomCase();
      logic [31:0] rnd;
      logic [7:0]  a;
      logic [7:0]  b;
      logic [1:0]  f;
      logic [15:0] sa;
      logic [15:0] sb;
      logic [15:0] res;
      rnd = $random(seed);
      a   = rnd[7:0];
      rnd = $random(seed);
      b   = rnd[7:0];
      rnd = $random(seed);
      f   = rnd[1:0];
      sa  = {{8{a[7]}}, a};
      sb  = {{8{b[7]}}, b};
      case (f)
         2'b00:   res = sa + sb;
         2'b01:   res = sb - sa;
         2'b10:   res = sa ^ sb;
         default: res = sa & ~sb;
      endcase
      names[6] = "random_rtype";
      progTab[6][0] = byteImmWord(`OP_LBI, 3'd1, a);
      progTab[6][1] = byteImmWord(`OP_LBI, 3'd2, b);
      progTab[6][2] = rWord(f, 3'd1, 3'd2, 3'd7);
      expectWrite(6, 3'd1, sa, 0);
      expectWrite(6, 3'd2, sb, 1);
      expectWrite(6, 3'd7, res, 2);
   endtask

   //////////////////////////////
   // Load, run and check one test
   //////////////////////////////
   task automatic runTest(input int t);
      int cycle;
      int errs;
      bit done;
      gotReg.delete();
      gotVal.delete();
      gotCycle.delete();
      errs = 0;
      done = 1'b0;
      // Program goes in under reset
      @(posedge clk);
      reset <= 1'b1;
      for (int i = 0; i < progLen; i++) begin
         @(posedge clk);
         loadEn   <= 1'b1;
         loadAddr <= 8'(i);
         loadData <= progTab[t][i];
      end
      @(posedge clk);
      loadEn <= 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      // Cycle 0 is the first fetch, sampled mid-cycle
      cycle = 0;
      while (!done) begin
         @(negedge clk);
         if (wbValid) begin
            gotReg.push_back(wbReg);
            gotVal.push_back(wbData);
            gotCycle.push_back(cycle);
         end
         if (halted) begin
            done = 1'b1;
         end else begin
            cycle++;
         end
      end
      // Halt holds, no more writes
      repeat (quietCycles) begin
         @(negedge clk);
         assert (halted === 1'b1 && wbValid === 1'b0) else begin
            $display("CHECK FAILED at time %0d ns: %s halted=%b wbValid=%b after HALT",
                     $time, names[t], halted, wbValid);
            errs++;
         end
      end
      assert (gotReg.size() == expCount[t]) else begin
         $display("CHECK FAILED at time %0d ns: %s saw %0d writes, expected %0d",
                  $time, names[t], gotReg.size(), expCount[t]);
         errs++;
      end
      for (int i = 0; i < expCount[t] && i < gotReg.size(); i++) begin
         assert (gotReg[i] === expReg[t][i] && gotVal[i] === expVal[t][i]) else begin
            $display("CHECK FAILED at time %0d ns: %s write %0d is r%0d=%h, expected r%0d=%h",
                     $time, names[t], i, gotReg[i], gotVal[i], expReg[t][i], expVal[t][i]);
            errs++;
         end
         assert (gotCycle[i] == 5 * expStep[t][i] + 4) else begin
            $display("CHECK FAILED at time %0d ns: %s write %0d in cycle %0d, expected %0d",
                     $time, names[t], i, gotCycle[i], 5 * expStep[t][i] + 4);
            errs++;
         end
      end
      if (errs == 0) begin
         passCount++;
         $display("Test %0d %s passed, %0d writes", t, names[t], gotReg.size());
      end else begin
         failCount++;
         $display("Test %0d %s failed with %0d errors", t, names[t], errs);
      end
   endtask

   // Watchdog
   initial begin
      #(watchdogNs);
      $display("Watchdog expired at time %0d ns, the processor never halted", $time);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      reset     = 1'b1;
      loadEn    = 1'b0;
      loadAddr  = '0;
      loadData  = '0;
      passCount = 0;
      failCount = 0;
      fillTable();
      buildRandomCase();
      for (int t = 0; t < numTests; t++) begin
         runTest(t);
      end
      $display("Tests passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/ctrlIf.sv
rtl/decode.sv
rtl/seqControl.sv
rtl/progCounter.sv
rtl/regFile.sv
rtl/alu.sv
rtl/instrMem.sv
rtl/dataMem.sv
rtl/cpuTop.sv
dv/cpuTb.sv
